//--- hw/rtc_read_pkg.sv
package rtc_read_pkg;

    ////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] rtc_addr_t;
    typedef logic [7:0] bcd_t;

    // Clock registers in chip order
    typedef struct packed {
        bcd_t sec;
        bcd_t min;
        bcd_t hour;
        bcd_t date;
        bcd_t month;
        bcd_t year;
        bcd_t day;
    } rtc_time_t;

    typedef struct packed {
        bcd_t sec;
        bcd_t min;
        bcd_t hour;
    } timer_set_t;

    ////////////////////////////////////////////////////////////
    // Register bus
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      start;
        rtc_addr_t addr;
    } rtc_bus_req_t;

    typedef struct packed {
        logic busy;
        logic rd_valid;
        bcd_t rd_data;
    } rtc_bus_rsp_t;

    // Reader side of the arbiter with req held for the whole group
    typedef struct packed {
        logic      req;
        logic      start;
        rtc_addr_t addr;
    } reader_bus_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam rtc_addr_t   CLOCK_CMD_ADDR    = 8'hf1;
    localparam rtc_addr_t   CLOCK_BASE_ADDR   = 8'h21;
    localparam int unsigned CLOCK_COUNT       = 7;

    localparam rtc_addr_t   TIMER_CMD_ADDR    = 8'hf2;
    localparam rtc_addr_t   TIMER_BASE_ADDR   = 8'h41;
    localparam int unsigned TIMER_COUNT       = 3;

    // Cycles the address is held before busy is looked at
    localparam int unsigned DEFAULT_ADDR_HOLD = 2;

endpackage

//--- hw/group_reader.sv
`timescale 1ns/1ns

module group_reader
    import rtc_read_pkg::*;
#(
    parameter rtc_addr_t   CMD_ADDR  = CLOCK_CMD_ADDR,
    parameter rtc_addr_t   BASE_ADDR = CLOCK_BASE_ADDR,
    parameter int unsigned COUNT     = CLOCK_COUNT,
    parameter int unsigned ADDR_HOLD = DEFAULT_ADDR_HOLD
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             group_enable,
    input  logic             scan_start,
    input  logic             grant,
    input  rtc_bus_rsp_t     bus_rsp,
    output reader_bus_t      bus_out,
    output logic             finished,
    output bcd_t [COUNT-1:0] values
);

    // Index 0 is the command, 1..COUNT the registers
    localparam int unsigned IDX_W  = $clog2(COUNT + 1);
    localparam int unsigned HOLD_W = $clog2(ADDR_HOLD + 1);

    localparam logic [IDX_W-1:0]  LAST_IDX  = IDX_W'(COUNT);
    localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(ADDR_HOLD);

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        HOLD,
        WAIT,
        DONE
    } state_t;

    state_t            state;
    logic [IDX_W-1:0]  index;
    logic [HOLD_W-1:0] hold_cnt;
    rtc_addr_t         cur_addr;
    logic              issue;
    logic              in_txn;
    logic              capture;

    ////////////////////////////////////////////////////////////
    // Transaction address and bus outputs
    ////////////////////////////////////////////////////////////

    assign issue  = (state == REQUEST) && grant;
    assign in_txn = (state == HOLD) || (state == WAIT);

    always_comb
    begin
        if (index == '0)
            cur_addr = CMD_ADDR;
        else
            cur_addr = BASE_ADDR + rtc_addr_t'(index) - rtc_addr_t'(1);
    end

    always_comb
    begin
        bus_out.req   = (state == REQUEST) || in_txn;
        bus_out.start = issue;
        // Address only shows while a transaction is open
        bus_out.addr  = (issue || in_txn) ? cur_addr : '0;
    end

    // Drops in the scan_start cycle itself
    assign finished = (state == DONE) && !scan_start;

    ////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= IDLE;
            index    <= '0;
            hold_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE, DONE:
                begin
                    if (scan_start)
                    begin
                        index <= '0;
                        if (group_enable)
                            state <= REQUEST;
                        else
                            state <= DONE;
                    end
                end

                REQUEST:
                begin
                    if (grant)
                    begin
                        hold_cnt <= HOLD_LOAD;
                        state    <= HOLD;
                    end
                end

                HOLD:
                begin
                    hold_cnt <= hold_cnt - 1'b1;
                    if (hold_cnt == HOLD_W'(1))
                        state <= WAIT;
                end

                WAIT:
                begin
                    // Transaction over on first cycle without busy
                    if (!bus_rsp.busy)
                    begin
                        if (index == LAST_IDX)
                        begin
                            state <= DONE;
                        end
                        else
                        begin
                            index <= index + 1'b1;
                            state <= REQUEST;
                        end
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Data capture
    ////////////////////////////////////////////////////////////

    // Command reply carries nothing worth keeping
    assign capture = in_txn && grant && bus_rsp.rd_valid && (index != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            values <= '0;
        else if (capture)
            values[index - 1'b1] <= bus_rsp.rd_data;
    end

endmodule

//--- hw/rtc_bus_arbiter.sv
`timescale 1ns/1ns

module rtc_bus_arbiter
    import rtc_read_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         scan_enable,
    input  reader_bus_t  clock_bus,
    input  reader_bus_t  timer_bus,
    input  logic         clock_finished,
    input  logic         timer_finished,
    output logic         clock_grant,
    output logic         timer_grant,
    output logic         scan_start,
    output rtc_bus_req_t bus_req,
    output logic         reading,
    output logic         scan_done
);

    typedef enum logic [1:0] {
        IDLE,
        SCANNING,
        CLOSING
    } state_t;

    state_t state;
    logic   all_finished;
    logic   clock_grant_next;
    logic   timer_grant_next;

    ////////////////////////////////////////////////////////////
    // Scan control
    ////////////////////////////////////////////////////////////

    assign all_finished = clock_finished && timer_finished;

    // A new scan may begin in the closing cycle itself
    assign scan_start = scan_enable && (state != SCANNING);
    assign scan_done  = (state == SCANNING) && all_finished;
    assign reading    = (state == SCANNING);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (scan_enable)
                        state <= SCANNING;
                end

                SCANNING:
                begin
                    if (all_finished)
                        state <= CLOSING;
                end

                CLOSING:
                begin
                    // Restart straight away or rest
                    if (scan_enable)
                        state <= SCANNING;
                    else
                        state <= IDLE;
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant with the clock reader first
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        clock_grant_next = 1'b0;
        timer_grant_next = 1'b0;
        if (clock_grant && clock_bus.req)
            clock_grant_next = 1'b1;
        else if (timer_grant && timer_bus.req)
            timer_grant_next = 1'b1;
        else if (clock_bus.req)
            clock_grant_next = 1'b1;
        else if (timer_bus.req)
            timer_grant_next = 1'b1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            clock_grant <= 1'b0;
            timer_grant <= 1'b0;
        end
        else
        begin
            clock_grant <= clock_grant_next;
            timer_grant <= timer_grant_next;
        end
    end

    // Bus stays at zero with nobody granted
    always_comb
    begin
        bus_req = '0;
        if (clock_grant)
        begin
            bus_req.start = clock_bus.start;
            bus_req.addr  = clock_bus.addr;
        end
        else if (timer_grant)
        begin
            bus_req.start = timer_bus.start;
            bus_req.addr  = timer_bus.addr;
        end
    end

endmodule

//--- hw/rtc_reader_top.sv
`timescale 1ns/1ns

module rtc_reader_top
    import rtc_read_pkg::*;
#(
    parameter int unsigned ADDR_HOLD = DEFAULT_ADDR_HOLD
)
(
    input  logic         clk,
    input  logic         reset,
    input  logic         scan_enable,
    input  logic         clock_enable,
    input  logic         timer_enable,
    input  rtc_bus_rsp_t bus_rsp,
    output rtc_bus_req_t bus_req,
    output rtc_time_t    rtc_time,
    output timer_set_t   timer_set,
    output logic         reading,
    output logic         scan_done
);

    reader_bus_t            clock_bus;
    reader_bus_t            timer_bus;
    logic                   clock_grant;
    logic                   timer_grant;
    logic                   clock_finished;
    logic                   timer_finished;
    logic                   scan_start;
    bcd_t [CLOCK_COUNT-1:0] clock_values;
    bcd_t [TIMER_COUNT-1:0] timer_values;

    ////////////////////////////////////////////////////////////
    // Readers
    ////////////////////////////////////////////////////////////

    group_reader #(
        .CMD_ADDR  (CLOCK_CMD_ADDR),
        .BASE_ADDR (CLOCK_BASE_ADDR),
        .COUNT     (CLOCK_COUNT),
        .ADDR_HOLD (ADDR_HOLD)
    ) clock_reader (
        .clk          (clk),
        .reset        (reset),
        .group_enable (clock_enable),
        .scan_start   (scan_start),
        .grant        (clock_grant),
        .bus_rsp      (bus_rsp),
        .bus_out      (clock_bus),
        .finished     (clock_finished),
        .values       (clock_values)
    );

    group_reader #(
        .CMD_ADDR  (TIMER_CMD_ADDR),
        .BASE_ADDR (TIMER_BASE_ADDR),
        .COUNT     (TIMER_COUNT),
        .ADDR_HOLD (ADDR_HOLD)
    ) timer_reader (
        .clk          (clk),
        .reset        (reset),
        .group_enable (timer_enable),
        .scan_start   (scan_start),
        .grant        (timer_grant),
        .bus_rsp      (bus_rsp),
        .bus_out      (timer_bus),
        .finished     (timer_finished),
        .values       (timer_values)
    );

    ////////////////////////////////////////////////////////////
    // Shared bus
    ////////////////////////////////////////////////////////////

    rtc_bus_arbiter arbiter (
        .clk            (clk),
        .reset          (reset),
        .scan_enable    (scan_enable),
        .clock_bus      (clock_bus),
        .timer_bus      (timer_bus),
        .clock_finished (clock_finished),
        .timer_finished (timer_finished),
        .clock_grant    (clock_grant),
        .timer_grant    (timer_grant),
        .scan_start     (scan_start),
        .bus_req        (bus_req),
        .reading        (reading),
        .scan_done      (scan_done)
    );

    // Slot 0 holds the lowest register address
    assign rtc_time.sec   = clock_values[0];
    assign rtc_time.min   = clock_values[1];
    assign rtc_time.hour  = clock_values[2];
    assign rtc_time.date  = clock_values[3];
    assign rtc_time.month = clock_values[4];
    assign rtc_time.year  = clock_values[5];
    assign rtc_time.day   = clock_values[6];

    assign timer_set.sec  = timer_values[0];
    assign timer_set.min  = timer_values[1];
    assign timer_set.hour = timer_values[2];

endmodule

//--- tb/rtc_bus_model.sv
`timescale 1ns/1ns

module rtc_bus_model
    import rtc_read_pkg::*;
#(
    parameter int unsigned SEED      = 32'hd4c4_b18b,
    parameter int unsigned LOG_DEPTH = 128
)
(
    input  logic         clk,
    input  logic         reset,
    input  rtc_bus_req_t bus_req,
    output rtc_bus_rsp_t bus_rsp
);

    // Register image, filled from outside before each scan
    bcd_t        image [256];
    rtc_addr_t   start_log [LOG_DEPTH];
    int unsigned log_count = 0;

    integer      busy_seed = SEED;
    logic        busy      = 1'b0;
    logic        rd_valid  = 1'b0;
    bcd_t        rd_data   = '0;
    rtc_addr_t   txn_addr  = '0;
    int unsigned busy_len  = 0;
    int unsigned busy_cnt  = 0;
    int unsigned valid_at  = 0;
    int unsigned len;

    assign bus_rsp = {busy, rd_valid, rd_data};

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            rd_valid  <= 1'b0;
            rd_data   <= '0;
            busy_cnt  <= 0;
            log_count <= 0;
        end
        else
        begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
            if (bus_req.start)
            begin
                // Busy for 2 to 5 cycles, data on the middle one
                len = 2 + ($unsigned($random(busy_seed)) % 4);
                busy     <= 1'b1;
                busy_len <= len;
                busy_cnt <= 1;
                valid_at <= (len + 1) / 2;
                txn_addr <= bus_req.addr;
                if ((len + 1) / 2 == 1)
                begin
                    rd_valid <= 1'b1;
                    rd_data  <= image[bus_req.addr];
                end
                if (log_count < LOG_DEPTH)
                    start_log[log_count] <= bus_req.addr;
                log_count <= log_count + 1;
            end
            else if (busy)
            begin
                if (busy_cnt == busy_len)
                begin
                    busy <= 1'b0;
                end
                else
                begin
                    busy_cnt <= busy_cnt + 1;
                    if (busy_cnt + 1 == valid_at)
                    begin
                        rd_valid <= 1'b1;
                        rd_data  <= image[txn_addr];
                    end
                end
            end
        end
    end

endmodule

//--- tb/rtc_reader_tb.sv
`timescale 1ns/1ns

module rtc_reader_tb
    import rtc_read_pkg::*;
;

    localparam int unsigned ADDR_HOLD      = DEFAULT_ADDR_HOLD;
    localparam int unsigned NUM_ROWS       = 6;
    localparam int unsigned TIMEOUT_CYCLES = NUM_ROWS * 13 * 12 + 200;

    typedef struct packed {
        logic       clock_en;
        logic       timer_en;
        logic [7:0] exp_starts;
    } row_t;

    logic         clk          = 1'b0;
    logic         reset        = 1'b1;
    logic         scan_enable  = 1'b0;
    logic         clock_enable = 1'b0;
    logic         timer_enable = 1'b0;
    rtc_bus_rsp_t bus_rsp;
    rtc_bus_req_t bus_req;
    rtc_time_t    rtc_time;
    timer_set_t   timer_set;
    logic         reading;
    logic         scan_done;

    row_t         rows [NUM_ROWS];
    bcd_t         image_copy [256];
    rtc_time_t    exp_time  = '0;
    timer_set_t   exp_timer = '0;
    integer       seed      = 32'hd4c4_b18b;

    int           bcd_errors   = 0;
    int           addr_errors  = 0;
    int           flag_errors  = 0;
    int           other_errors = 0;
    int unsigned  cycle_count  = 0;
    int unsigned  done_count   = 0;

    logic         txn_open = 1'b0;
    rtc_addr_t    txn_addr = '0;
    int unsigned  txn_age  = 0;
    int           r;

    rtc_reader_top #(
        .ADDR_HOLD (ADDR_HOLD)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .scan_enable  (scan_enable),
        .clock_enable (clock_enable),
        .timer_enable (timer_enable),
        .bus_rsp      (bus_rsp),
        .bus_req      (bus_req),
        .rtc_time     (rtc_time),
        .timer_set    (timer_set),
        .reading      (reading),
        .scan_done    (scan_done)
    );

    rtc_bus_model bus_model (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_bcd(input string name, input bcd_t actual, input bcd_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
            bcd_errors++;
        end
    endtask

    task automatic check_addr(input string name, input rtc_addr_t actual,
                              input rtc_addr_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
            addr_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, actual, expected);
            flag_errors++;
        end
    endtask

    task automatic check_outputs();
        check_bcd("rtc_time.sec", rtc_time.sec, exp_time.sec);
        check_bcd("rtc_time.min", rtc_time.min, exp_time.min);
        check_bcd("rtc_time.hour", rtc_time.hour, exp_time.hour);
        check_bcd("rtc_time.date", rtc_time.date, exp_time.date);
        check_bcd("rtc_time.month", rtc_time.month, exp_time.month);
        check_bcd("rtc_time.year", rtc_time.year, exp_time.year);
        check_bcd("rtc_time.day", rtc_time.day, exp_time.day);
        check_bcd("timer_set.sec", timer_set.sec, exp_timer.sec);
        check_bcd("timer_set.min", timer_set.min, exp_timer.min);
        check_bcd("timer_set.hour", timer_set.hour, exp_timer.hour);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic set_row(input int idx, input logic c, input logic t, input logic [7:0] n);
        rows[idx].clock_en   = c;
        rows[idx].timer_en   = t;
        rows[idx].exp_starts = n;
    endtask

    task automatic fill_image();
        for (int i = 0; i < 256; i++)
        begin
            image_copy[i]      = bcd_t'($random(seed));
            bus_model.image[i] = image_copy[i];
        end
    endtask

    // Field k of a group sits at its base address plus k
    task automatic update_expected(input row_t row);
        if (row.clock_en)
        begin
            exp_time.sec   = image_copy[CLOCK_BASE_ADDR + 8'd0];
            exp_time.min   = image_copy[CLOCK_BASE_ADDR + 8'd1];
            exp_time.hour  = image_copy[CLOCK_BASE_ADDR + 8'd2];
            exp_time.date  = image_copy[CLOCK_BASE_ADDR + 8'd3];
            exp_time.month = image_copy[CLOCK_BASE_ADDR + 8'd4];
            exp_time.year  = image_copy[CLOCK_BASE_ADDR + 8'd5];
            exp_time.day   = image_copy[CLOCK_BASE_ADDR + 8'd6];
        end
        if (row.timer_en)
        begin
            exp_timer.sec  = image_copy[TIMER_BASE_ADDR + 8'd0];
            exp_timer.min  = image_copy[TIMER_BASE_ADDR + 8'd1];
            exp_timer.hour = image_copy[TIMER_BASE_ADDR + 8'd2];
        end
    endtask

    task automatic run_row(input int idx);
        rtc_addr_t   exp_addrs [$];
        int unsigned first_log;
        int unsigned done_before;
        int unsigned n;
        begin
            fill_image();
            first_log   = bus_model.log_count;
            done_before = done_count;
            @(posedge clk);
            clock_enable <= rows[idx].clock_en;
            timer_enable <= rows[idx].timer_en;
            scan_enable  <= 1'b1;
            // Cycle of scan_start
            @(negedge clk);
            check_flag("reading", reading, 1'b0);
            check_flag("scan_done", scan_done, 1'b0);
            do
            begin
                @(negedge clk);
                check_flag("reading", reading, 1'b1);
            end
            while (scan_done !== 1'b1);
            @(posedge clk);
            scan_enable <= 1'b0;
            repeat (3) @(negedge clk);
            check_flag("reading", reading, 1'b0);
            if (done_count - done_before != 1)
            begin
                $display("Row %0d: scan_done pulsed %0d times instead of once",
                         idx, done_count - done_before);
                other_errors++;
            end

            if (rows[idx].clock_en)
            begin
                exp_addrs.push_back(CLOCK_CMD_ADDR);
                for (int k = 0; k < CLOCK_COUNT; k++)
                    exp_addrs.push_back(CLOCK_BASE_ADDR + rtc_addr_t'(k));
            end
            if (rows[idx].timer_en)
            begin
                exp_addrs.push_back(TIMER_CMD_ADDR);
                for (int k = 0; k < TIMER_COUNT; k++)
                    exp_addrs.push_back(TIMER_BASE_ADDR + rtc_addr_t'(k));
            end
            n = bus_model.log_count - first_log;
            if (n != rows[idx].exp_starts || n != exp_addrs.size())
            begin
                $display("Row %0d: %0d bus transactions started, %0d expected",
                         idx, n, rows[idx].exp_starts);
                other_errors++;
            end
            for (int k = 0; k < exp_addrs.size() && k < n; k++)
                check_addr($sformatf("start_log[%0d]", first_log + k),
                           bus_model.start_log[first_log + k], exp_addrs[k]);

            update_expected(rows[idx]);
            check_outputs();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus monitor and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (scan_done)
                done_count++;
            if (bus_req.start)
            begin
                if (txn_open)
                begin
                    $display("Start at %0t came while a transaction was still open", $time);
                    other_errors++;
                end
                check_flag("bus_req.addr nonzero", bus_req.addr != '0, 1'b1);
                txn_open = 1'b1;
                txn_addr = bus_req.addr;
                txn_age  = 0;
            end
            else if (txn_open)
            begin
                txn_age++;
                check_addr("bus_req.addr", bus_req.addr, txn_addr);
                // Ends on first busy-low cycle after the hold
                if (txn_age > ADDR_HOLD && !bus_rsp.busy)
                    txn_open = 1'b0;
            end
            else
            begin
                check_addr("bus_req.addr", bus_req.addr, '0);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the scans did not complete", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        set_row(0, 1'b1, 1'b1, 8'd12);
        set_row(1, 1'b1, 1'b0, 8'd8);
        set_row(2, 1'b0, 1'b1, 8'd4);
        set_row(3, 1'b0, 1'b0, 8'd0);
        set_row(4, 1'b1, 1'b1, 8'd12);
        set_row(5, 1'b0, 1'b1, 8'd4);

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("reading", reading, 1'b0);
        check_flag("scan_done", scan_done, 1'b0);
        check_flag("bus_req.start", bus_req.start, 1'b0);
        check_addr("bus_req.addr", bus_req.addr, '0);
        check_outputs();

        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);

        $display("Errors: bcd %0d, addr %0d, flag %0d, other %0d",
                 bcd_errors, addr_errors, flag_errors, other_errors);
        if (bcd_errors + addr_errors + flag_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- flist.f
hw/rtc_read_pkg.sv
hw/group_reader.sv
hw/rtc_bus_arbiter.sv
hw/rtc_reader_top.sv
tb/rtc_bus_model.sv
tb/rtc_reader_tb.sv

//--- Bender.yml
package:
  name: rtc_reader

sources:
  - hw/rtc_read_pkg.sv
  - hw/group_reader.sv
  - hw/rtc_bus_arbiter.sv
  - hw/rtc_reader_top.sv
  - target: test
    files:
      - tb/rtc_bus_model.sv
      - tb/rtc_reader_tb.sv
